// ==== hdl/cp0Pkg.sv ====
// ==============================
// Exception/timer subset of MIPS32 CP0 only, no TLB registers
// ExcCode literals carry a code prefix since int is a keyword
// ==============================

package cp0Pkg;

    // CP0 register numbers, select 0 only
    typedef enum logic [4:0] {
        badVAddr = 5'd8,
        count    = 5'd9,
        compare  = 5'd11,
        status   = 5'd12,
        cause    = 5'd13,
        epc      = 5'd14,
        prid     = 5'd15
    } cp0RegE;

    // What retires in the last memory stage
    typedef enum logic [4:0] {
        excNone,
        excRefetch,
        excEret,
        excInterrupt,
        excTlbMod,
        excTlbLoadIf,
        excTlbLoadMem,
        excTlbStore,
        excAddrIf,
        excAddrLoad,
        excAddrStore,
        excSyscall,
        excBreak,
        excReserved,
        excCpU,
        excOverflow,
        excTrap
    } excTypeE;

    // Architectural Cause.ExcCode values
    typedef enum logic [4:0] {
        codeInt  = 5'd0,
        codeMod  = 5'd1,
        codeTlbl = 5'd2,
        codeTlbs = 5'd3,
        codeAdel = 5'd4,
        codeAdes = 5'd5,
        codeSys  = 5'd8,
        codeBp   = 5'd9,
        codeRi   = 5'd10,
        codeCpu  = 5'd11,
        codeOv   = 5'd12,
        codeTr   = 5'd13
    } excCodeE;

    typedef struct packed {
        logic        wrEn;
        cp0RegE      addr;
        logic [31:0] data;
    } cp0WriteS;

    typedef struct packed {
        excTypeE     excType;
        logic [31:0] pc;
        logic [31:0] badAddr;     // Memory-stage address
        logic        inDelaySlot;
    } excReqS;

    typedef struct packed {
        logic       cu0;
        logic       bev;
        logic [7:0] im;
        logic       um;
        logic       erl;
        logic       exl;
        logic       ie;
    } statusS;

    typedef struct packed {
        logic       bd;
        logic       ti;
        logic [1:0] ce;
        logic [5:0] ipHw;         // IP7..2
        logic [1:0] ipSw;         // IP1..0
        excCodeE    excCode;
    } causeS;

    // Boot exception vectors selected out of reset
    localparam statusS statusResetC = '{
        cu0: 1'b0, bev: 1'b1, im: 8'h00, um: 1'b0, erl: 1'b0, exl: 1'b0, ie: 1'b0
    };

    localparam logic [31:0] pridValueC    = 32'h0000_4220;
    localparam logic [31:0] compareResetC = 32'hFFFF_FFFF;

endpackage

// ==== hdl/cp0Timer.sv ====
// ==============================
// Count ticks at half the core clock
// TI stays set until Compare is written
// ==============================
`timescale 1ns/1ps

module cp0Timer (
    input  logic             clk,
    input  logic             rstN,
    input  cp0Pkg::cp0WriteS wr,
    output logic [31:0]      count,
    output logic [31:0]      compare,
    output logic             timerInt
);

    logic phase;        // Divide-by-two toggle
    logic countWr;
    logic compareWr;

    assign countWr   = wr.wrEn && (wr.addr == cp0Pkg::count);
    assign compareWr = wr.wrEn && (wr.addr == cp0Pkg::compare);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= 1'b0;
            count <= '0;
        end else if (countWr) begin
            phase <= 1'b0;          // Restart the divider on a write
            count <= wr.data;
        end else begin
            phase <= ~phase;
            if (phase) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            compare <= cp0Pkg::compareResetC;
        end else if (compareWr) begin
            compare <= wr.data;
        end
    end

    // Sticky flag, write to Compare acknowledges it
    always_ff @(posedge clk) begin
        if (!rstN) begin
            timerInt <= 1'b0;
        end else if (compareWr) begin
            timerInt <= 1'b0;
        end else if (count == compare) begin
            timerInt <= 1'b1;
        end
    end

endmodule

// ==== hdl/cp0StatusCause.sv ====
// ==============================
// Exceptions take priority over MTC0 on EXL
// Cause.BD is filled in by the top level
// ==============================
`timescale 1ns/1ps

module cp0StatusCause (
    input  logic             clk,
    input  logic             rstN,
    input  cp0Pkg::cp0WriteS wr,
    input  cp0Pkg::excReqS   exc,
    input  logic [5:0]       hwInt,
    input  logic             timerInt,
    output cp0Pkg::statusS   status,
    output cp0Pkg::causeS    cause
);

    logic            statusWr;
    logic            causeWr;
    logic            excTaken;
    logic [5:0]      ipHw;
    logic [1:0]      ipSw;
    logic [1:0]      ce;
    cp0Pkg::excCodeE excCode;

    assign statusWr = wr.wrEn && (wr.addr == cp0Pkg::status);
    assign causeWr  = wr.wrEn && (wr.addr == cp0Pkg::cause);
    assign excTaken = (exc.excType != cp0Pkg::excNone) && (exc.excType != cp0Pkg::excRefetch);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            status <= cp0Pkg::statusResetC;
        end else begin
            if (statusWr) begin
                status.cu0 <= wr.data[28];
                status.bev <= wr.data[22];
                status.im  <= wr.data[15:8];
                status.um  <= wr.data[4];
                status.erl <= wr.data[2];
                status.ie  <= wr.data[0];
            end
            // EXL: exception entry and ERET override the write
            if (excTaken) begin
                status.exl <= (exc.excType != cp0Pkg::excEret);
            end else if (statusWr) begin
                status.exl <= wr.data[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ipHw <= '0;
            ipSw <= '0;
            ce   <= '0;
        end else begin
            ipHw <= hwInt | {timerInt, 5'b0};   // Timer shares IP7
            if (causeWr) begin
                ipSw <= wr.data[9:8];
            end
            if (exc.excType == cp0Pkg::excCpU) begin
                ce <= 2'b01;                    // Only CP1 unusable is reported
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            excCode <= cp0Pkg::codeInt;
        end else begin
            case (exc.excType)
                cp0Pkg::excInterrupt:  excCode <= cp0Pkg::codeInt;
                cp0Pkg::excTlbMod:     excCode <= cp0Pkg::codeMod;
                cp0Pkg::excTlbLoadIf,
                cp0Pkg::excTlbLoadMem: excCode <= cp0Pkg::codeTlbl;
                cp0Pkg::excTlbStore:   excCode <= cp0Pkg::codeTlbs;
                cp0Pkg::excAddrIf,
                cp0Pkg::excAddrLoad:   excCode <= cp0Pkg::codeAdel;
                cp0Pkg::excAddrStore:  excCode <= cp0Pkg::codeAdes;
                cp0Pkg::excSyscall:    excCode <= cp0Pkg::codeSys;
                cp0Pkg::excBreak:      excCode <= cp0Pkg::codeBp;
                cp0Pkg::excReserved:   excCode <= cp0Pkg::codeRi;
                cp0Pkg::excCpU:        excCode <= cp0Pkg::codeCpu;
                cp0Pkg::excOverflow:   excCode <= cp0Pkg::codeOv;
                cp0Pkg::excTrap:       excCode <= cp0Pkg::codeTr;
                default:               excCode <= excCode;  // None, refetch, ERET
            endcase
        end
    end

    assign cause = '{
        bd: 1'b0, ti: timerInt, ce: ce, ipHw: ipHw, ipSw: ipSw, excCode: excCode
    };

endmodule

// ==== hdl/cp0ExcRecord.sv ====
// ==============================
// EPC and BD hold while EXL is set
// ==============================
`timescale 1ns/1ps

module cp0ExcRecord (
    input  logic             clk,
    input  logic             rstN,
    input  cp0Pkg::cp0WriteS wr,
    input  cp0Pkg::excReqS   exc,
    input  logic             exl,
    output logic [31:0]      epc,
    output logic [31:0]      badVAddr,
    output logic             causeBd
);

    logic excEntry;     // New exception level entered this cycle
    logic epcWr;
    logic pcFault;
    logic addrFault;

    assign excEntry = !exl
                   && (exc.excType != cp0Pkg::excNone)
                   && (exc.excType != cp0Pkg::excRefetch)
                   && (exc.excType != cp0Pkg::excEret);
    assign epcWr    = wr.wrEn && (wr.addr == cp0Pkg::epc);

    // Fetch-side faults report the PC itself
    assign pcFault   = (exc.excType == cp0Pkg::excAddrIf)
                    || (exc.excType == cp0Pkg::excTlbLoadIf);
    assign addrFault = (exc.excType == cp0Pkg::excAddrLoad)
                    || (exc.excType == cp0Pkg::excAddrStore)
                    || (exc.excType == cp0Pkg::excTlbLoadMem)
                    || (exc.excType == cp0Pkg::excTlbStore)
                    || (exc.excType == cp0Pkg::excTlbMod);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            epc     <= '0;
            causeBd <= 1'b0;
        end else if (excEntry) begin
            // Branch in front of the slot is the restart point
            epc     <= exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;
            causeBd <= exc.inDelaySlot;
        end else if (epcWr) begin
            epc     <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            badVAddr <= '0;
        end else if (pcFault) begin
            badVAddr <= exc.pc;
        end else if (addrFault) begin
            badVAddr <= exc.badAddr;
        end
    end

endmodule

// ==== hdl/cp0ReadMux.sv ====
// ==============================
// Unimplemented register numbers read as zero
// ==============================
`timescale 1ns/1ps

module cp0ReadMux (
    input  cp0Pkg::cp0RegE rdAddr,
    input  cp0Pkg::statusS status,
    input  cp0Pkg::causeS  cause,
    input  logic [31:0]    count,
    input  logic [31:0]    compare,
    input  logic [31:0]    epc,
    input  logic [31:0]    badVAddr,
    output logic [31:0]    rdData
);

    logic [31:0] statusWord;
    logic [31:0] causeWord;

    // Architectural bit positions
    assign statusWord = {3'b0, status.cu0, 5'b0, status.bev, 6'b0, status.im,
                         3'b0, status.um, 1'b0, status.erl, status.exl, status.ie};
    assign causeWord  = {cause.bd, cause.ti, cause.ce, 12'b0, cause.ipHw, cause.ipSw,
                         1'b0, cause.excCode, 2'b0};

    always_comb begin
        case (rdAddr)
            cp0Pkg::badVAddr: rdData = badVAddr;
            cp0Pkg::count:    rdData = count;
            cp0Pkg::compare:  rdData = compare;
            cp0Pkg::status:   rdData = statusWord;
            cp0Pkg::cause:    rdData = causeWord;
            cp0Pkg::epc:      rdData = epc;
            cp0Pkg::prid:     rdData = cp0Pkg::pridValueC;
            default:          rdData = '0;
        endcase
    end

endmodule

// ==== hdl/cp0Top.sv ====
// ==============================
// Write port and exception record sampled every cycle
// ==============================
`timescale 1ns/1ps

module cp0Top (
    input  logic             clk,
    input  logic             rstN,
    input  logic [5:0]       hwInt,
    input  cp0Pkg::cp0WriteS wr,
    input  cp0Pkg::excReqS   exc,
    input  cp0Pkg::cp0RegE   rdAddr,
    output logic [31:0]      rdData,
    output cp0Pkg::statusS   status,
    output cp0Pkg::causeS    cause,
    output logic [31:0]      epc
);

    logic [31:0]   count;
    logic [31:0]   compare;
    logic          timerInt;
    logic [31:0]   badVAddr;
    logic          causeBd;
    cp0Pkg::causeS causeCore;   // Cause without BD

    cp0Timer timer_i (
        .clk      (clk),
        .rstN     (rstN),
        .wr       (wr),
        .count    (count),
        .compare  (compare),
        .timerInt (timerInt)
    );

    cp0StatusCause statusCause_i (
        .clk      (clk),
        .rstN     (rstN),
        .wr       (wr),
        .exc      (exc),
        .hwInt    (hwInt),
        .timerInt (timerInt),
        .status   (status),
        .cause    (causeCore)
    );

    cp0ExcRecord excRecord_i (
        .clk      (clk),
        .rstN     (rstN),
        .wr       (wr),
        .exc      (exc),
        .exl      (status.exl),
        .epc      (epc),
        .badVAddr (badVAddr),
        .causeBd  (causeBd)
    );

    assign cause = '{
        bd: causeBd, ti: causeCore.ti, ce: causeCore.ce, ipHw: causeCore.ipHw,
        ipSw: causeCore.ipSw, excCode: causeCore.excCode
    };

    cp0ReadMux readMux_i (
        .rdAddr   (rdAddr),
        .status   (status),
        .cause    (cause),
        .count    (count),
        .compare  (compare),
        .epc      (epc),
        .badVAddr (badVAddr),
        .rdData   (rdData)
    );

endmodule

// ==== testbench/cp0Top_props.sv ====
// ==============================
// Bound into cp0Top, sees the internal count and compare
// ==============================
`timescale 1ns/1ps

module cp0Top_props (
    input logic             clk,
    input logic             rstN,
    input cp0Pkg::cp0WriteS wr,
    input cp0Pkg::excReqS   exc,
    input cp0Pkg::statusS   status,
    input cp0Pkg::causeS    cause,
    input logic [31:0]      count,
    input logic [31:0]      compare
);

    logic excEntry;     // Taken exception other than ERET
    logic countWr;

    assign excEntry = (exc.excType != cp0Pkg::excNone) && (exc.excType != cp0Pkg::excRefetch)
                   && (exc.excType != cp0Pkg::excEret);
    assign countWr  = wr.wrEn && (wr.addr == cp0Pkg::count);

    exlSet: assert property (@(posedge clk) disable iff (!rstN) excEntry |=> status.exl)
        else $error("EXL not set after exception entry");

    tiRise: assert property (@(posedge clk) disable iff (!rstN)
        $rose(cause.ti) |-> $past(count == compare))
        else $error("TI rose without a Count/Compare match");

    // Divider allows one increment per two cycles
    countStep: assert property (@(posedge clk) disable iff (!rstN)
        (count != $past(count)) && !$past(countWr) && !countWr |=> count == $past(count))
        else $error("Count changed on two consecutive cycles without a write");

endmodule

bind cp0Top cp0Top_props props_i (
    .clk(clk), .rstN(rstN), .wr(wr), .exc(exc), .status(status), .cause(cause),
    .count(count), .compare(compare)
);

// ==== testbench/cp0Tb.sv ====
// ==============================
// Random CP0 traffic from a fixed seed against a cycle model
// Stops at the first mismatch
// ==============================
`timescale 1ns/1ps

module cp0Tb;

    localparam int numCycles     = 2000;
    localparam int timeoutCycles = numCycles + numCycles / 2;

    // ExcCode per exception type, indexed by excTypeE
    localparam logic [4:0] codeMap [17] = '{5'd0, 5'd0, 5'd0, 5'd0, 5'd1, 5'd2, 5'd2, 5'd3,
                                            5'd4, 5'd4, 5'd5, 5'd8, 5'd9, 5'd10, 5'd11,
                                            5'd12, 5'd13};

    logic             clk;
    logic             rstN;
    logic [5:0]       hwInt;
    cp0Pkg::cp0WriteS wr;
    cp0Pkg::excReqS   exc;
    cp0Pkg::cp0RegE   rdAddr;
    logic [31:0]      rdData;
    cp0Pkg::statusS   status;
    cp0Pkg::causeS    cause;
    logic [31:0]      epc;
    int               cycles = 0;

    // Reference model state
    cp0Pkg::statusS   mStatus;
    cp0Pkg::causeS    mCause;
    logic [31:0]      mCount;
    logic [31:0]      mCompare;
    logic             mPhase;      // Count divider
    logic [31:0]      mEpc;
    logic [31:0]      mBad;

    cp0Top cp0Top_i (
        .clk(clk), .rstN(rstN), .hwInt(hwInt), .wr(wr), .exc(exc),
        .rdAddr(rdAddr), .rdData(rdData), .status(status), .cause(cause), .epc(epc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("Timeout, the run did not finish within %0d cycles", timeoutCycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        $display("sim failed");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) reportMismatch(name, exp, act);
    endtask

    task automatic checkStatus(input string name, input cp0Pkg::statusS exp,
                               input cp0Pkg::statusS act);
        if (act !== exp) reportMismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic checkCause(input string name, input cp0Pkg::causeS exp,
                              input cp0Pkg::causeS act);
        if (act !== exp) reportMismatch(name, 32'(exp), 32'(act));
    endtask

    // Architectural layout of each register word
    function automatic logic [31:0] readModel(input cp0Pkg::cp0RegE a);
        case (a)
            cp0Pkg::badVAddr: return mBad;
            cp0Pkg::count:    return mCount;
            cp0Pkg::compare:  return mCompare;
            cp0Pkg::status:   return {3'b0, mStatus.cu0, 5'b0, mStatus.bev, 6'b0, mStatus.im,
                                      3'b0, mStatus.um, 1'b0, mStatus.erl, mStatus.exl, mStatus.ie};
            cp0Pkg::cause:    return {mCause.bd, mCause.ti, mCause.ce, 12'b0, mCause.ipHw,
                                      mCause.ipSw, 1'b0, mCause.excCode, 2'b0};
            cp0Pkg::epc:      return mEpc;
            cp0Pkg::prid:     return 32'h0000_4220;
            default:          return 32'h0;
        endcase
    endfunction

    // Next state from the inputs of this cycle, old values read before they change
    task automatic stepModel();
        logic [31:0] d;
        logic        taken;
        d     = wr.data;
        taken = exc.excType != cp0Pkg::excNone && exc.excType != cp0Pkg::excRefetch;
        if (taken && exc.excType != cp0Pkg::excEret && !mStatus.exl) begin
            mEpc      = exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;
            mCause.bd = exc.inDelaySlot;
        end else if (wr.wrEn && wr.addr == cp0Pkg::epc) begin
            mEpc = d;
        end
        if (wr.wrEn && wr.addr == cp0Pkg::status) begin
            mStatus = '{cu0: d[28], bev: d[22], im: d[15:8], um: d[4], erl: d[2], exl: d[1],
                        ie: d[0]};
        end
        if (taken) mStatus.exl = exc.excType != cp0Pkg::excEret;   // Beats the write
        if (wr.wrEn && wr.addr == cp0Pkg::cause) mCause.ipSw = d[9:8];
        if (exc.excType == cp0Pkg::excCpU) mCause.ce = 2'd1;
        if (exc.excType > cp0Pkg::excEret) begin
            mCause.excCode = cp0Pkg::excCodeE'(codeMap[exc.excType]);
        end
        mCause.ipHw = hwInt | {mCause.ti, 5'b0};                    // Still the old TI
        if (wr.wrEn && wr.addr == cp0Pkg::compare) begin
            mCause.ti = 1'b0;
            mCompare  = d;
        end else if (mCount == mCompare) begin
            mCause.ti = 1'b1;
        end
        if (wr.wrEn && wr.addr == cp0Pkg::count) begin
            mCount = d;
            mPhase = 1'b0;
        end else begin
            mCount = mCount + {31'b0, mPhase};
            mPhase = ~mPhase;
        end
        if (exc.excType == cp0Pkg::excAddrIf || exc.excType == cp0Pkg::excTlbLoadIf) begin
            mBad = exc.pc;
        end else if (exc.excType inside {cp0Pkg::excAddrLoad, cp0Pkg::excAddrStore,
                     cp0Pkg::excTlbLoadMem, cp0Pkg::excTlbStore, cp0Pkg::excTlbMod}) begin
            mBad = exc.badAddr;
        end
    endtask

    // Registers 8..15, where 10 stands for any number
    function automatic cp0Pkg::cp0RegE pickReg();
        logic [4:0] n;
        n = 5'd8 + 5'($urandom % 8);
        if (n == 5'd10) n = 5'($urandom);
        return cp0Pkg::cp0RegE'(n);
    endfunction

    task automatic driveInputs();
        int unsigned r;
        r       = $urandom % 16;
        wr.wrEn = ($urandom % 4) == 0;
        wr.addr = pickReg();
        wr.data = $urandom;
        // Keep Count near Compare now and then so TI fires
        if (wr.addr == cp0Pkg::compare && $urandom % 2 == 1) wr.data = mCount + ($urandom % 8);
        if (wr.addr == cp0Pkg::count && $urandom % 2 == 1) wr.data = mCompare - ($urandom % 8);
        exc.excType = cp0Pkg::excNone;
        if (r == 0) exc.excType = cp0Pkg::excEret;
        if (r == 1) exc.excType = cp0Pkg::excTypeE'(5'($urandom % 17));
        exc.pc          = $urandom & 32'hFFFF_FFFC;
        exc.badAddr     = $urandom;
        exc.inDelaySlot = $urandom % 2 == 1;
        if ($urandom % 4 == 0) hwInt = 6'($urandom);
        rdAddr = pickReg();
    endtask

    initial begin
        void'($urandom(32'h95e05412));
        rstN        = 1'b0;
        hwInt       = '0;
        wr          = '0;
        exc         = '0;
        rdAddr      = cp0Pkg::prid;
        mStatus     = '0;
        mStatus.bev = 1'b1;          // Boot vectors out of reset
        mCause      = '0;
        mCount      = '0;
        mCompare    = 32'hFFFF_FFFF;
        mPhase      = 1'b0;
        mEpc        = '0;
        mBad        = '0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        for (int i = 0; i < numCycles; i++) begin
            checkStatus("status", mStatus, status);
            checkCause("cause", mCause, cause);
            checkWord("epc", mEpc, epc);
            driveInputs();
            #1;
            checkWord($sformatf("read reg %0d", rdAddr), readModel(rdAddr), rdData);
            stepModel();
            @(posedge clk);
            #1;
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/cp0Pkg.sv
hdl/cp0Timer.sv
hdl/cp0StatusCause.sv
hdl/cp0ExcRecord.sv
hdl/cp0ReadMux.sv
hdl/cp0Top.sv
testbench/cp0Top_props.sv
testbench/cp0Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module cp0Tb -f build.f -o cp0Sim &&
    ./obj_dir/cp0Sim ||
    exit 1
